//--- hw/data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram (
    input  logic                       clk,
    input  lsu_pkg::ram_req_t          ram_req,
    output logic [lsu_pkg::DATA_W-1:0] rdata
);
    import lsu_pkg::*;

    logic [DATA_W-1:0] mem [RAM_DEPTH];

    // one port, write has priority, read data lands next cycle
    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            if (|ram_req.wen) begin
                for (int i = 0; i < BE_W; i++) begin
                    if (ram_req.wen[i]) begin
                        mem[ram_req.addr][8*i +: 8] <= ram_req.wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[ram_req.addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/load_align.sv
`timescale 1ns/100ps
`default_nettype none

module load_align (
    input  logic                       clk,
    input  logic                       arst_n,
    input  lsu_pkg::ls_req_t           req,
    input  logic                       load_go,
    input  logic [lsu_pkg::DATA_W-1:0] rdata,
    output lsu_pkg::load_rsp_t         rsp
);
    import lsu_pkg::*;

    ls_sel_e           sel_q;
    logic [1:0]        off_q;
    logic [DATA_W-1:0] rt_q;
    logic              valid_q;
    logic [7:0]        byte_v;
    logic [15:0]       half_v;

    // ############################
    // mem stage register
    // ############################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= load_go;
        end
    end

    always_ff @(posedge clk) begin
        if (load_go) begin
            sel_q <= req.sel;
            off_q <= req.addr[1:0];
            rt_q  <= req.rt_data;   // old rt, needed by lwl/lwr
        end
    end

    // ############################
    // extract and merge
    // ############################
    assign byte_v = rdata[{off_q, 3'b000} +: 8];
    assign half_v = rdata[{off_q[1], 4'b0000} +: 16];

    always_comb begin
        rsp.valid = valid_q;
        rsp.data  = '0;
        case (sel_q)
            LB:  rsp.data = {{24{byte_v[7]}}, byte_v};
            LBU: rsp.data = {24'h0, byte_v};
            LH:  rsp.data = {{16{half_v[15]}}, half_v};
            LHU: rsp.data = {16'h0, half_v};
            LW:  rsp.data = rdata;
            LWL: begin
                case (off_q)   // mem bytes 0..k go to the top
                    2'd0: rsp.data = {rdata[7:0],  rt_q[23:0]};
                    2'd1: rsp.data = {rdata[15:0], rt_q[15:0]};
                    2'd2: rsp.data = {rdata[23:0], rt_q[7:0]};
                    default: rsp.data = rdata;
                endcase
            end
            LWR: begin
                case (off_q)   // mem bytes k..3 go to the bottom
                    2'd0: rsp.data = rdata;
                    2'd1: rsp.data = {rt_q[31:24], rdata[31:8]};
                    2'd2: rsp.data = {rt_q[31:16], rdata[31:16]};
                    default: rsp.data = {rt_q[31:8], rdata[31:24]};
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ############################
    // sizing
    // ############################
    localparam int DATA_W    = 32;
    localparam int BE_W      = DATA_W / 8;   // byte lanes per word
    localparam int RAM_AW    = 10;
    localparam int RAM_DEPTH = 1 << RAM_AW;

    // access opcodes from decode, NONE means no memory access
    typedef enum logic [3:0] {
        NONE = 4'h0,
        LB   = 4'h1,
        LBU  = 4'h2,
        LH   = 4'h3,
        LHU  = 4'h4,
        LW   = 4'h5,
        LWL  = 4'h6,
        LWR  = 4'h7,
        SB   = 4'h8,
        SH   = 4'h9,
        SW   = 4'ha,
        SWL  = 4'hb,
        SWR  = 4'hc
    } ls_sel_e;

    // ############################
    // request / response types
    // ############################
    typedef struct packed {
        logic              en;
        ls_sel_e           sel;
        logic [31:0]       addr;      // byte address
        logic [DATA_W-1:0] rt_data;   // store data or old rt for lwl/lwr
        logic              refetch;
    } ls_req_t;

    typedef struct packed {
        logic adel;
        logic ades;
    } ls_exc_t;

    typedef struct packed {
        logic              en;
        logic [BE_W-1:0]   wen;
        logic [RAM_AW-1:0] addr;      // word index
        logic [DATA_W-1:0] wdata;
    } ram_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } load_rsp_t;

endpackage

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
    input  logic               clk,
    input  logic               arst_n,
    input  lsu_pkg::ls_req_t   req,
    input  logic               ex_has_exception,
    input  logic               mem_has_exception,
    output lsu_pkg::ls_exc_t   exc,
    output lsu_pkg::load_rsp_t rsp
);
    import lsu_pkg::*;

    ram_req_t          ram_req;
    logic [DATA_W-1:0] rdata;
    logic              load_go;   // load granted this cycle

    // ############################
    // execute side
    // ############################
    mem_ctrl mem_ctrl_i (
        .req               (req),
        .ex_has_exception  (ex_has_exception),
        .mem_has_exception (mem_has_exception),
        .exc               (exc),
        .ram_req           (ram_req),
        .load_go           (load_go)
    );

    // ############################
    // data ram
    // ############################
    data_ram data_ram_i (
        .clk     (clk),
        .ram_req (ram_req),
        .rdata   (rdata)
    );

    // ############################
    // memory stage
    // ############################
    load_align load_align_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .load_go (load_go),
        .rdata   (rdata),
        .rsp     (rsp)
    );

endmodule

`default_nettype wire

//--- hw/mem_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl (
    input  lsu_pkg::ls_req_t  req,
    input  logic              ex_has_exception,
    input  logic              mem_has_exception,
    output lsu_pkg::ls_exc_t  exc,
    output lsu_pkg::ram_req_t ram_req,
    output logic              load_go
);
    import lsu_pkg::*;

    logic [1:0]        off;
    logic              is_load;
    logic              access;
    logic [BE_W-1:0]   st_wen;
    logic [DATA_W-1:0] st_wdata;

    assign off = req.addr[1:0];

    // ############################
    // opcode class
    // ############################
    always_comb begin
        is_load = 1'b0;
        case (req.sel)
            LB, LBU, LH, LHU, LW, LWL, LWR: is_load = 1'b1;
            default: ;
        endcase
    end

    // ############################
    // address errors
    // ############################
    always_comb begin
        exc.adel = 1'b0;
        exc.ades = 1'b0;
        if (req.en) begin
            case (req.sel)
                LH, LHU: exc.adel = off[0];
                LW:      exc.adel = |off;
                SH:      exc.ades = off[0];
                SW:      exc.ades = |off;
                default: ;  // byte and unaligned ops never fault
            endcase
        end
    end

    // blocked by older exceptions, a flush from mem, or our own fault
    assign access = req.en & ~ex_has_exception & ~mem_has_exception & ~req.refetch
                  & ~exc.adel & ~exc.ades & (req.sel != NONE);

    // ############################
    // store lane placement
    // ############################
    always_comb begin
        st_wen   = '0;
        st_wdata = '0;
        case (req.sel)
            SB: begin
                st_wen   = 4'b0001 << off;
                st_wdata = {4{req.rt_data[7:0]}};   // replicated on all lanes
            end
            SH: begin
                st_wen   = 4'b0011 << off;   // off is 0 or 2 here
                st_wdata = {2{req.rt_data[15:0]}};
            end
            SW: begin
                st_wen   = 4'b1111;
                st_wdata = req.rt_data;
            end
            SWL: begin
                // lanes 0..k take the top bytes of rt
                st_wen   = 4'b1111 >> (2'd3 - off);
                st_wdata = req.rt_data >> {2'd3 - off, 3'b000};
            end
            SWR: begin
                st_wen   = 4'b1111 << off;   // lanes k..3
                st_wdata = req.rt_data << {off, 3'b000};
            end
            default: ;
        endcase
    end

    assign ram_req.en    = access;
    assign ram_req.wen   = {BE_W{access}} & st_wen;   // st_wen is zero for loads
    assign ram_req.addr  = req.addr[RAM_AW+1:2];   // drop byte offset
    assign ram_req.wdata = st_wdata;

    assign load_go = access & is_load;

endmodule

`default_nettype wire

//--- lsu_top.f
+incdir+verif
hw/lsu_pkg.sv
hw/mem_ctrl.sv
hw/data_ram.sv
hw/load_align.sv
hw/lsu_top.sv
verif/lsu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds lsu_tb with verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -j 0 \
    --top-module lsu_tb -f lsu_top.f -o lsu_sim || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/lsu_sim)"
echo "$sim_out"
grep -qx "sim passed" <<< "$sim_out" && exit 0 || exit 1

//--- verif/lsu_tb_tasks.svh
`ifndef LSU_TB_TASKS_SVH
`define LSU_TB_TASKS_SVH

// ############################
// reference model
// ############################
logic [DATA_W-1:0] shadow [RAM_DEPTH];   // expected RAM words
load_rsp_t         exp_rsp;              // response due in the next cycle

function automatic ls_req_t make_req(input ls_sel_e sel, input logic [31:0] addr,
                                     input logic [DATA_W-1:0] rt);
    ls_req_t r;
    r         = '0;
    r.en      = 1'b1;
    r.sel     = sel;
    r.addr    = addr;
    r.rt_data = rt;
    return r;
endfunction

function automatic logic [31:0] rand_word_addr();
    return 32'(RAM_AW'($urandom_range(RAM_DEPTH - 1, 0))) << 2;
endfunction

function automatic ls_exc_t predict_exc(input ls_req_t r);
    ls_exc_t e;
    e = '0;
    if (r.en) begin
        case (r.sel)
            LH, LHU: e.adel = r.addr[0];
            LW:      e.adel = (r.addr[1:0] != 2'b00);
            SH:      e.ades = r.addr[0];
            SW:      e.ades = (r.addr[1:0] != 2'b00);
            default: ;
        endcase
    end
    return e;
endfunction

function automatic void update_shadow(input ls_req_t r);
    int                k;
    logic [3:0]        lanes;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] mask;
    k = int'(r.addr[1:0]);
    case (r.sel)
        SB:      lanes = 4'b0001 << k;
        SH:      lanes = 4'b0011 << k;
        SWL:     lanes = 4'b1111 >> (3 - k);   // lanes 0..k
        SWR:     lanes = 4'b1111 << k;         // lanes k..3
        default: lanes = 4'b1111;
    endcase
    case (r.sel)
        SB:      data = {4{r.rt_data[7:0]}};
        SH:      data = {2{r.rt_data[15:0]}};
        SWL:     data = r.rt_data >> (8 * (3 - k));
        SWR:     data = r.rt_data << (8 * k);
        default: data = r.rt_data;
    endcase
    mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    shadow[r.addr[RAM_AW+1:2]] = (shadow[r.addr[RAM_AW+1:2]] & ~mask) | (data & mask);
endfunction

function automatic logic [DATA_W-1:0] predict_load(input ls_req_t r);
    int                k;
    logic [DATA_W-1:0] w;
    logic [DATA_W-1:0] keep;
    logic [7:0]        b;
    logic [15:0]       h;
    k = int'(r.addr[1:0]);
    w = shadow[r.addr[RAM_AW+1:2]];
    b = 8'(w >> (8 * k));
    h = 16'(w >> (8 * k));
    case (r.sel)
        LB:  return {{24{b[7]}}, b};
        LBU: return {24'h0, b};
        LH:  return {{16{h[15]}}, h};
        LHU: return {16'h0, h};
        LWL: begin
            // memory bytes 0..k end up on top, rt keeps its low 3-k bytes
            keep = 32'hffff_ffff >> (8 * (k + 1));
            return (w << (8 * (3 - k))) | (r.rt_data & keep);
        end
        LWR: begin
            keep = ~(32'hffff_ffff >> (8 * k));
            return (w >> (8 * k)) | (r.rt_data & keep);
        end
        default: return w;
    endcase
endfunction

// ############################
// compare tasks
// ############################
task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                          input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
        abort_run($sformatf("ERROR at %0d ns: %s expected %h, got %h",
                            $time, name, expected, actual));
    end
endtask

task automatic check_exc(input string name, input ls_exc_t expected, input ls_exc_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("ERROR at %0d ns: %s {adel,ades} expected %b, got %b",
                            $time, name, expected, actual));
    end
endtask

task automatic check_rsp(input string name, input load_rsp_t expected,
                         input load_rsp_t actual);
    if (actual.valid !== expected.valid) begin
        abort_run($sformatf("ERROR at %0d ns: %s.valid expected %b, got %b",
                            $time, name, expected.valid, actual.valid));
    end
    if (expected.valid) begin
        check_word({name, ".data"}, expected.data, actual.data);
    end
endtask

// ############################
// drive tasks
// ############################
task automatic drive_cycle(input ls_req_t r, input logic ex_exc = 1'b0,
                           input logic mem_exc = 1'b0);
    ls_exc_t exp_exc;
    logic    go;
    @(negedge clk);
    check_rsp("rsp", exp_rsp, rsp);   // load issued in the previous cycle
    req               = r;
    ex_has_exception  = ex_exc;
    mem_has_exception = mem_exc;
    #1;
    exp_exc = predict_exc(r);
    check_exc("exc", exp_exc, exc);
    go      = r.en & ~ex_exc & ~mem_exc & ~r.refetch & ~exp_exc.adel & ~exp_exc.ades;
    exp_rsp = '0;
    if (go && r.sel inside {LB, LBU, LH, LHU, LW, LWL, LWR}) begin
        exp_rsp.valid = 1'b1;
        exp_rsp.data  = predict_load(r);
    end
    if (go && r.sel inside {SB, SH, SW, SWL, SWR}) begin
        update_shadow(r);
    end
endtask

task automatic idle_cycle();
    drive_cycle(ls_req_t'(0));
endtask

// ############################
// directed tests
// ############################
task automatic word_round_trip();
    logic [31:0] addrs [$];
    for (int i = 0; i < 8; i++) begin
        addrs.push_back(rand_word_addr());
        drive_cycle(make_req(SW, addrs[i], $urandom()));
    end
    foreach (addrs[i]) begin
        drive_cycle(make_req(LW, addrs[i], $urandom()));
        idle_cycle();   // valid has to drop again
    end
endtask

task automatic subword_access();
    logic [31:0] a;
    logic [31:0] w;
    a = rand_word_addr();
    drive_cycle(make_req(SW, a, 32'h5ac3_817e));
    for (int k = 0; k < 4; k++) begin
        w    = $urandom();
        w[7] = k[0];   // both signs of the byte
        drive_cycle(make_req(SB, a + k, w));
        drive_cycle(make_req(LB, a + k, $urandom()));
        drive_cycle(make_req(LBU, a + k, $urandom()));
    end
    for (int k = 0; k < 4; k += 2) begin
        w     = $urandom();
        w[15] = k[1];
        drive_cycle(make_req(SH, a + k, w));
        drive_cycle(make_req(LH, a + k, $urandom()));
        drive_cycle(make_req(LHU, a + k, $urandom()));
    end
    for (int k = 0; k < 4; k++) begin
        drive_cycle(make_req(LB, a + k, 0));
        drive_cycle(make_req(LBU, a + k, 0));
        if (k[0] == 1'b0) begin
            drive_cycle(make_req(LH, a + k, 0));
            drive_cycle(make_req(LHU, a + k, 0));
        end
    end
endtask

task automatic unaligned_pair();
    logic [31:0] a;
    a = rand_word_addr();
    for (int k = 0; k < 4; k++) begin
        drive_cycle(make_req(SW, a, 32'h0123_4567));
        drive_cycle(make_req(SWL, a + k, $urandom()));
        drive_cycle(make_req(LW, a, 0));
        drive_cycle(make_req(SW, a, 32'h89ab_cdef));
        drive_cycle(make_req(SWR, a + k, $urandom()));
        drive_cycle(make_req(LW, a, 0));
    end
    drive_cycle(make_req(SW, a, $urandom()));
    for (int k = 0; k < 4; k++) begin
        drive_cycle(make_req(LWL, a + k, $urandom()));
        drive_cycle(make_req(LWR, a + k, $urandom()));
    end
endtask

task automatic address_errors();
    ls_sel_e     ops [5] = '{LH, LHU, LW, SH, SW};
    logic [31:0] a;
    a = rand_word_addr();
    drive_cycle(make_req(SW, a, $urandom()));
    foreach (ops[s]) begin
        for (int k = 1; k < 4; k++) begin
            // offset 2 is legal for halfwords
            if (!(ops[s] inside {LH, LHU, SH} && k == 2)) begin
                drive_cycle(make_req(ops[s], a + k, $urandom()));
            end
        end
    end
    drive_cycle(make_req(LW, a, 0));   // word must be unchanged
    idle_cycle();
endtask

task automatic suppression();
    ls_req_t     r;
    logic [31:0] a;
    a = rand_word_addr();
    drive_cycle(make_req(SW, a, $urandom()));
    // c: 0 ex exception, 1 mem exception, 2 refetch, 3 en low
    for (int c = 0; c < 4; c++) begin
        r         = make_req(SW, a, $urandom());
        r.refetch = (c == 2);
        r.en      = (c != 3);
        drive_cycle(r, c == 0, c == 1);
        r.sel = LW;
        drive_cycle(r, c == 0, c == 1);
    end
    drive_cycle(make_req(LW, a, 0));
    idle_cycle();
endtask

task automatic pipelined_loads();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = rand_word_addr();
    b = a ^ 32'h4;
    c = a ^ 32'h8;
    for (int i = 0; i < 3; i++) begin
        drive_cycle(make_req(SW, a ^ (i << 2), $urandom()));
    end
    for (int i = 0; i < 3; i++) begin
        drive_cycle(make_req(LW, a ^ (i << 2), 0));   // back to back
    end
    // store then load of the same word in consecutive cycles
    drive_cycle(make_req(SW, a, $urandom()));
    drive_cycle(make_req(LW, a, 0));
    drive_cycle(make_req(SB, b + 3, $urandom()));
    drive_cycle(make_req(LB, b + 3, 0));
    drive_cycle(make_req(SWL, c + 1, $urandom()));
    drive_cycle(make_req(LWR, c + 2, $urandom()));
    drive_cycle(make_req(LW, c, 0));
    idle_cycle();
endtask

`endif

//--- verif/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int SEED        = 32'h9267;
    // round trip, sub-word, unaligned, addr errors, suppression, pipelining
    localparam int TEST_CYCLES = 24 + 31 + 33 + 15 + 11 + 14;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 3 + 50) * CLK_PERIOD;   // reset, drain, margin

    logic      clk;
    logic      arst_n;
    ls_req_t   req;
    logic      ex_has_exception;
    logic      mem_has_exception;
    ls_exc_t   exc;
    load_rsp_t rsp;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    `include "lsu_tb_tasks.svh"

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    lsu_top dut_i (
        .clk               (clk),
        .arst_n            (arst_n),
        .req               (req),
        .ex_has_exception  (ex_has_exception),
        .mem_has_exception (mem_has_exception),
        .exc               (exc),
        .rsp               (rsp)
    );

    // ############################
    // watchdog
    // ############################
    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("watchdog expired after %0d ns, the tests did not finish",
                            WATCHDOG_NS));
    end

    // ############################
    // test sequence
    // ############################
    initial begin
        void'($urandom(SEED));
        arst_n            = 1'b0;
        req               = '0;
        ex_has_exception  = 1'b0;
        mem_has_exception = 1'b0;
        exp_rsp           = '0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        word_round_trip();
        subword_access();
        unaligned_pair();
        address_errors();
        suppression();
        pipelined_loads();
        idle_cycle();   // collects the last response

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
